// File: all.f
logic/mem_pkg.sv
logic/mem_bank.sv
logic/port_arbiter.sv
logic/req_fifo.sv
logic/line_engine.sv
logic/mem_main.sv
verif/mem_main_tb.sv

// File: Makefile
# Verilator build and run of the line memory testbench

VERILATOR ?= verilator
TOP       ?= mem_main_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/mem_main_tb.sv
module mem_main_tb;

  localparam int clk_period = 8;
  localparam int n_port = mem_pkg::num_rt + 1;
  // mc sits after the rt ports in every per-port array
  localparam int mc_port = mem_pkg::num_rt;
  localparam int n_lines = 1 << mem_pkg::idx_w;
  // cycles a request may wait for its rdy
  localparam int rdy_bound = 64;
  // quiet cycles watched after the last completion
  localparam int settle_cycles = 8;
  localparam int random_reqs = 200;
  // 2 + 8 + 7 directed requests, then the random traffic
  localparam int total_reqs = 17 + random_reqs;
  localparam int watchdog_cycles = total_reqs * 200 + 100;

  logic                                             clk;
  logic                                             rst_n;
  logic [mem_pkg::num_rt-1:0]                       rt_req;
  logic [mem_pkg::num_rt-1:0]                       rt_we;
  logic [mem_pkg::num_rt-1:0][mem_pkg::addr_w-1:0]  rt_addr;
  logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]  rt_wdata;
  logic [mem_pkg::num_rt-1:0]                       rt_rdy;
  logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]  rt_rdata;
  logic                                             mc_re;
  logic [mem_pkg::addr_w-1:0]                       mc_addr;
  logic                                             mc_rdy;
  logic [mem_pkg::line_w-1:0]                       mc_rdata;

  // reference memory, updated when a write completes
  logic [mem_pkg::line_w-1:0] model [n_lines];
  logic                       known [n_lines];
  // one outstanding request per port
  logic                       busy [n_port];
  logic                       is_wr [n_port];
  logic [mem_pkg::idx_w-1:0]  cur_idx [n_port];
  logic [mem_pkg::line_w-1:0] cur_wdata [n_port];
  logic [mem_pkg::line_w-1:0] last_rdata [n_port];
  int                         age [n_port];
  logic [31:0]                rng_state;

  mem_main dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .rt_req   (rt_req),
    .rt_we    (rt_we),
    .rt_addr  (rt_addr),
    .rt_wdata (rt_wdata),
    .rt_rdy   (rt_rdy),
    .rt_rdata (rt_rdata),
    .mc_re    (mc_re),
    .mc_addr  (mc_addr),
    .mc_rdy   (mc_rdy),
    .mc_rdata (mc_rdata)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [mem_pkg::line_w-1:0] rand_line();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // call at a falling edge, after collect_rdy
  task automatic issue_req(input int p, input logic wr, input logic [mem_pkg::idx_w-1:0] idx,
                           input logic [mem_pkg::line_w-1:0] data);
    logic [mem_pkg::addr_w-1:0] addr;
    // junk in the upper and low bits, only 11:4 pick the line
    addr = (32'(p * 3 + 1) << 12) | (32'(idx) << mem_pkg::idx_lo) | 32'(p);
    busy[p] = 1'b1;
    is_wr[p] = wr;
    cur_idx[p] = idx;
    cur_wdata[p] = data;
    age[p] = 0;
    if (p < mem_pkg::num_rt) begin
      rt_req[p] = 1'b1;
      rt_we[p] = wr;
      rt_addr[p] = addr;
      rt_wdata[p] = data;
    end else begin
      mc_re = 1'b1;
      mc_addr = addr;
    end
  endtask

  // sample every rdy at the falling edge and check against the model
  task automatic collect_rdy();
    logic                       r;
    logic [mem_pkg::line_w-1:0] d;
    for (int p = 0; p < n_port; p++) begin
      if (p < mem_pkg::num_rt) begin
        r = rt_rdy[p];
        d = rt_rdata[p];
      end else begin
        r = mc_rdy;
        d = mc_rdata;
      end
      if (r) begin
        assert (busy[p]) else
          stop_run($sformatf("port %0d pulsed rdy with no request outstanding", p));
        if (is_wr[p]) begin
          assert (d === '0) else
            stop_run($sformatf("Fail at %0t: port %0d write completion data %h, expected 0",
                               $time, p, d));
          model[cur_idx[p]] = cur_wdata[p];
          known[cur_idx[p]] = 1'b1;
        end else begin
          assert (d === model[cur_idx[p]]) else
            stop_run($sformatf("Fail at %0t: port %0d line %0d read %h, expected %h",
                               $time, p, cur_idx[p], d, model[cur_idx[p]]));
        end
        last_rdata[p] = d;
        busy[p] = 1'b0;
        // drop the request after its rdy
        if (p < mem_pkg::num_rt) begin
          rt_req[p] = 1'b0;
        end else begin
          mc_re = 1'b0;
        end
      end else if (busy[p]) begin
        age[p]++;
        assert (age[p] <= rdy_bound) else
          stop_run($sformatf("port %0d got no rdy within %0d cycles", p, rdy_bound));
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    collect_rdy();
  endtask

  task automatic wait_idle();
    logic any;
    any = 1'b1;
    while (any) begin
      tick();
      any = 1'b0;
      for (int p = 0; p < n_port; p++) begin
        if (busy[p]) begin
          any = 1'b1;
        end
      end
    end
  endtask

  // nothing requested, nothing completes
  task automatic check_idle_quiet();
    repeat (10) begin
      tick();
      assert (rt_rdy === '0 && mc_rdy === 1'b0) else
        stop_run($sformatf("Fail at %0t: rdy high with no request", $time));
    end
  endtask

  task automatic write_then_read();
    logic [mem_pkg::line_w-1:0] data;
    data = rand_line();
    issue_req(0, 1'b1, 8'd5, data);
    wait_idle();
    assert (last_rdata[0] === '0) else
      stop_run($sformatf("Fail at %0t: write completion data not zero", $time));
    issue_req(0, 1'b0, 8'd5, '0);
    wait_idle();
    assert (last_rdata[0] === data) else
      stop_run($sformatf("Fail at %0t: read back %h, expected %h", $time, last_rdata[0], data));
  endtask

  // fill lines 16..19, then all rt ports read at once
  task automatic four_port_reads();
    for (int p = 0; p < mem_pkg::num_rt; p++) begin
      issue_req(p, 1'b1, mem_pkg::idx_w'(16 + p), rand_line());
    end
    wait_idle();
    for (int p = 0; p < mem_pkg::num_rt; p++) begin
      issue_req(p, 1'b0, mem_pkg::idx_w'(16 + p), '0);
    end
    wait_idle();
    // a second rdy on any port trips the busy check
    repeat (settle_cycles) tick();
  endtask

  task automatic mc_shared_line();
    logic [mem_pkg::line_w-1:0] data;
    data = rand_line();
    issue_req(2, 1'b1, 8'd40, data);
    wait_idle();
    issue_req(mc_port, 1'b0, 8'd40, '0);
    wait_idle();
    assert (last_rdata[mc_port] === data) else
      stop_run($sformatf("Fail at %0t: mc read %h, expected %h", $time,
                         last_rdata[mc_port], data));
    // mc and every rt port at once
    issue_req(mc_port, 1'b0, 8'd40, '0);
    for (int p = 0; p < mem_pkg::num_rt; p++) begin
      issue_req(p, 1'b0, mem_pkg::idx_w'(16 + p), '0);
    end
    wait_idle();
    // a second rdy on any port trips the busy check
    repeat (settle_cycles) tick();
  endtask

  // rt port p owns lines 128+16p..143+16p, mc reads 16..19
  task automatic random_traffic();
    int                        sent;
    logic [31:0]               r;
    logic                      wr;
    logic [mem_pkg::idx_w-1:0] idx;
    sent = 0;
    while (sent < random_reqs) begin
      tick();
      for (int p = 0; p < n_port; p++) begin
        r = rand_word();
        // idle now and then
        if (!busy[p] && sent < random_reqs && r[2:0] != 3'd0) begin
          if (p == mc_port) begin
            idx = mem_pkg::idx_w'(16 + int'(r[9:8]));
            wr = 1'b0;
          end else begin
            idx = mem_pkg::idx_w'(128 + p * 16 + int'(r[7:4]));
            // never read a line that was not written
            wr = r[8] || !known[idx];
          end
          issue_req(p, wr, idx, wr ? rand_line() : '0);
          sent++;
        end
      end
    end
    wait_idle();
    // a repeated rdy trips the busy check
    repeat (settle_cycles) tick();
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    rt_req = '0;
    rt_we = '0;
    rt_addr = '0;
    rt_wdata = '0;
    mc_re = 1'b0;
    mc_addr = '0;
    rng_state = 32'd66;
    for (int i = 0; i < n_lines; i++) begin
      model[i] = '0;
      known[i] = 1'b0;
    end
    for (int p = 0; p < n_port; p++) begin
      busy[p] = 1'b0;
      is_wr[p] = 1'b0;
      cur_idx[p] = '0;
      cur_wdata[p] = '0;
      last_rdata[p] = '0;
      age[p] = 0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_idle_quiet();
    write_then_read();
    four_port_reads();
    mc_shared_line();
    random_traffic();
    $display("TB PASSED");
    $finish;
  end

  // bound on the whole run
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout, the run did not finish within %0d cycles", watchdog_cycles);
    $display("TB FAILED");
    $fatal(1);
  end

endmodule

// File: logic/mem_main.sv
module mem_main (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [mem_pkg::num_rt-1:0]                       rt_req,
  input  logic [mem_pkg::num_rt-1:0]                       rt_we,
  input  logic [mem_pkg::num_rt-1:0][mem_pkg::addr_w-1:0]  rt_addr,
  input  logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]  rt_wdata,
  output logic [mem_pkg::num_rt-1:0]                       rt_rdy,
  output logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]  rt_rdata,
  input  logic                                             mc_re,
  input  logic [mem_pkg::addr_w-1:0]                       mc_addr,
  output logic                                             mc_rdy,
  output logic [mem_pkg::line_w-1:0]                       mc_rdata
);

  // arbiter to queue
  logic                        push_valid;
  logic                        push_ready;
  mem_pkg::mem_op_e            a_op;
  mem_pkg::mem_src_e           a_src;
  logic [mem_pkg::idx_w-1:0]   a_idx;
  logic [mem_pkg::line_w-1:0]  a_wdata;
  // queue to engine
  logic                        pop_valid;
  logic                        pop_ready;
  mem_pkg::mem_op_e            f_op;
  mem_pkg::mem_src_e           f_src;
  logic [mem_pkg::idx_w-1:0]   f_idx;
  logic [mem_pkg::line_w-1:0]  f_wdata;
  // completion back to arbiter
  logic                        done_valid;
  mem_pkg::mem_src_e           done_src;

  port_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .rt_req     (rt_req),
    .rt_we      (rt_we),
    .rt_addr    (rt_addr),
    .rt_wdata   (rt_wdata),
    .mc_re      (mc_re),
    .mc_addr    (mc_addr),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .q_op       (a_op),
    .q_src      (a_src),
    .q_idx      (a_idx),
    .q_wdata    (a_wdata),
    .done_valid (done_valid),
    .done_src   (done_src)
  );

  req_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .in_op      (a_op),
    .in_src     (a_src),
    .in_idx     (a_idx),
    .in_wdata   (a_wdata),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .out_op     (f_op),
    .out_src    (f_src),
    .out_idx    (f_idx),
    .out_wdata  (f_wdata)
  );

  line_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .q_op       (f_op),
    .q_src      (f_src),
    .q_idx      (f_idx),
    .q_wdata    (f_wdata),
    .rt_rdy     (rt_rdy),
    .rt_rdata   (rt_rdata),
    .mc_rdy     (mc_rdy),
    .mc_rdata   (mc_rdata),
    .done_valid (done_valid),
    .done_src   (done_src)
  );

endmodule

// File: logic/line_engine.sv
module line_engine (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             pop_valid,
  output logic                                             pop_ready,
  input  mem_pkg::mem_op_e                                 q_op,
  input  mem_pkg::mem_src_e                                q_src,
  input  logic [mem_pkg::idx_w-1:0]                        q_idx,
  input  logic [mem_pkg::line_w-1:0]                       q_wdata,
  output logic [mem_pkg::num_rt-1:0]                       rt_rdy,
  output logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]  rt_rdata,
  output logic                                             mc_rdy,
  output logic [mem_pkg::line_w-1:0]                       mc_rdata,
  output logic                                             done_valid,
  output mem_pkg::mem_src_e                                done_src
);

  // stage 1 holds the popped entry while the banks are driven
  logic                                         s1_valid;
  mem_pkg::mem_op_e                             s1_op;
  mem_pkg::mem_src_e                            s1_src;
  logic [mem_pkg::idx_w-1:0]                    s1_idx;
  logic [mem_pkg::line_w-1:0]                   s1_wdata;
  // stage 2 follows the bank read
  logic                                         s2_valid;
  mem_pkg::mem_op_e                             s2_op;
  mem_pkg::mem_src_e                            s2_src;
  logic [mem_pkg::num_bank-1:0][mem_pkg::word_w-1:0] bank_dout;
  logic                                         bank_we;
  logic [mem_pkg::line_w-1:0]                   rsp_line;

  // never stalls
  assign pop_ready = 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= pop_valid && pop_ready;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op <= q_op;
    s1_src <= q_src;
    s1_idx <= q_idx;
    s1_wdata <= q_wdata;
    s2_op <= s1_op;
    s2_src <= s1_src;
  end

  // all four banks share one index, word n to bank n
  assign bank_we = s1_valid && (s1_op == mem_pkg::op_write);

  for (genvar n = 0; n < mem_pkg::num_bank; n++) begin : g_bank
    mem_bank u_bank (
      .clk  (clk),
      .we   (bank_we),
      .idx  (s1_idx),
      .din  (s1_wdata[n*mem_pkg::word_w +: mem_pkg::word_w]),
      .dout (bank_dout[n])
    );
  end

  // completion pulse to the owning source
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_rdy <= '0;
      mc_rdy <= 1'b0;
      done_valid <= 1'b0;
      done_src <= mem_pkg::src_rt0;
    end else begin
      for (int n = 0; n < mem_pkg::num_rt; n++) begin
        rt_rdy[n] <= s2_valid && (int'(s2_src) == n);
      end
      mc_rdy <= s2_valid && (s2_src == mem_pkg::src_mc);
      done_valid <= s2_valid;
      done_src <= s2_src;
    end
  end

  // writes complete with zero data
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      rsp_line <= (s2_op == mem_pkg::op_write) ? '0 : bank_dout;
    end
  end

  // one response bus, only meaningful under rdy
  always_comb begin
    for (int n = 0; n < mem_pkg::num_rt; n++) begin
      rt_rdata[n] = rsp_line;
    end
  end
  assign mc_rdata = rsp_line;

  a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({mc_rdy, rt_rdy}));

endmodule

// File: logic/req_fifo.sv
module req_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push_valid,
  output logic                        push_ready,
  input  mem_pkg::mem_op_e            in_op,
  input  mem_pkg::mem_src_e           in_src,
  input  logic [mem_pkg::idx_w-1:0]   in_idx,
  input  logic [mem_pkg::line_w-1:0]  in_wdata,
  output logic                        pop_valid,
  input  logic                        pop_ready,
  output mem_pkg::mem_op_e            out_op,
  output mem_pkg::mem_src_e           out_src,
  output logic [mem_pkg::idx_w-1:0]   out_idx,
  output logic [mem_pkg::line_w-1:0]  out_wdata
);

  // entry storage
  mem_pkg::mem_op_e            op_mem    [mem_pkg::fifo_depth];
  mem_pkg::mem_src_e           src_mem   [mem_pkg::fifo_depth];
  logic [mem_pkg::idx_w-1:0]   idx_mem   [mem_pkg::fifo_depth];
  logic [mem_pkg::line_w-1:0]  wdata_mem [mem_pkg::fifo_depth];

  logic [mem_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [mem_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [mem_pkg::fifo_cnt_w-1:0] count;
  logic                           push_fire;
  logic                           pop_fire;

  assign push_ready = (count != mem_pkg::fifo_cnt_w'(mem_pkg::fifo_depth));
  assign pop_valid = (count != '0);
  assign push_fire = push_valid && push_ready;
  assign pop_fire = pop_valid && pop_ready;

  // head of queue
  assign out_op = op_mem[rd_ptr];
  assign out_src = src_mem[rd_ptr];
  assign out_idx = idx_mem[rd_ptr];
  assign out_wdata = wdata_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_fire) begin
      op_mem[wr_ptr] <= in_op;
      src_mem[wr_ptr] <= in_src;
      idx_mem[wr_ptr] <= in_idx;
      wdata_mem[wr_ptr] <= in_wdata;
    end
  end

  // pointers wrap at depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (int'(wr_ptr) == mem_pkg::fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (int'(rd_ptr) == mem_pkg::fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(count) == mem_pkg::fifo_depth) |-> !push_fire);

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    int'(count) <= mem_pkg::fifo_depth);

endmodule

// File: logic/port_arbiter.sv
module port_arbiter (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [mem_pkg::num_rt-1:0]                        rt_req,
  input  logic [mem_pkg::num_rt-1:0]                        rt_we,
  input  logic [mem_pkg::num_rt-1:0][mem_pkg::addr_w-1:0]   rt_addr,
  input  logic [mem_pkg::num_rt-1:0][mem_pkg::line_w-1:0]   rt_wdata,
  input  logic                                              mc_re,
  input  logic [mem_pkg::addr_w-1:0]                        mc_addr,
  output logic                                              push_valid,
  input  logic                                              push_ready,
  output mem_pkg::mem_op_e                                  q_op,
  output mem_pkg::mem_src_e                                 q_src,
  output logic [mem_pkg::idx_w-1:0]                         q_idx,
  output logic [mem_pkg::line_w-1:0]                        q_wdata,
  input  logic                                              done_valid,
  input  mem_pkg::mem_src_e                                 done_src
);

  // one mark per source, mc in the top bit
  logic [mem_pkg::num_rt:0]          inflight;
  logic [mem_pkg::num_rt-1:0]        rt_elig;
  logic                              mc_elig;
  logic [mem_pkg::rt_sel_w-1:0]      rr_last;
  logic [mem_pkg::rt_sel_w-1:0]      rt_pick;
  logic                              rt_found;
  logic [mem_pkg::num_rt:0]          grant;
  logic                              push_fire;

  assign rt_elig = rt_req & ~inflight[mem_pkg::num_rt-1:0];
  assign mc_elig = mc_re & ~inflight[mem_pkg::num_rt];

  // round robin, search starts one past last grant
  always_comb begin
    logic [mem_pkg::rt_sel_w-1:0] cand;
    rt_pick = rr_last;
    rt_found = 1'b0;
    for (int i = 1; i <= mem_pkg::num_rt; i++) begin
      cand = mem_pkg::rt_sel_w'((int'(rr_last) + i) % mem_pkg::num_rt);
      if (!rt_found && rt_elig[cand]) begin
        rt_pick = cand;
        rt_found = 1'b1;
      end
    end
  end

  // mc has fixed priority
  always_comb begin
    grant = '0;
    if (mc_elig) begin
      grant[mem_pkg::num_rt] = 1'b1;
    end else if (rt_found) begin
      grant[rt_pick] = 1'b1;
    end
  end

  assign push_valid = |grant;
  assign push_fire = push_valid && push_ready;

  // entry fields for the granted source
  always_comb begin
    if (mc_elig) begin
      q_op = mem_pkg::op_read;
      q_src = mem_pkg::src_mc;
      q_idx = mc_addr[mem_pkg::idx_lo +: mem_pkg::idx_w];
      // mc only reads
      q_wdata = '0;
    end else begin
      q_op = rt_we[rt_pick] ? mem_pkg::op_write : mem_pkg::op_read;
      q_src = mem_pkg::mem_src_e'({1'b0, rt_pick});
      q_idx = rt_addr[rt_pick][mem_pkg::idx_lo +: mem_pkg::idx_w];
      q_wdata = rt_wdata[rt_pick];
    end
  end

  // set on push, clear on completion
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      if (done_valid) begin
        inflight[done_src] <= 1'b0;
      end
      if (push_fire) begin
        inflight[q_src] <= 1'b1;
      end
    end
  end

  // pointer moves only on an rt push
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_last <= mem_pkg::rt_sel_w'(mem_pkg::num_rt - 1);
    end else if (push_fire && !mc_elig) begin
      rr_last <= rt_pick;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant));

  // engine only completes what was pushed here
  a_done_inflight: assert property (@(posedge clk) disable iff (!rst_n)
    done_valid |-> inflight[done_src]);

endmodule

// File: logic/mem_bank.sv
module mem_bank (
  input  logic                       clk,
  input  logic                       we,
  input  logic [mem_pkg::idx_w-1:0]  idx,
  input  logic [mem_pkg::word_w-1:0] din,
  output logic [mem_pkg::word_w-1:0] dout
);

  // one word per line index
  logic [mem_pkg::word_w-1:0] mem [0:(1 << mem_pkg::idx_w)-1];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= din;
    end
  end

  // registered read, old data on a same-edge write
  always_ff @(posedge clk) begin
    dout <= mem[idx];
  end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

  // port counts
  localparam int num_rt = 4;
  localparam int rt_sel_w = $clog2(num_rt);

  // one bank per 32-bit word of a line
  localparam int num_bank = 4;

  // data widths
  localparam int word_w = 32;
  localparam int line_w = num_bank * word_w;
  localparam int addr_w = 32;

  // line index sits at byte-address bits 11:4
  localparam int idx_lo = 4;
  localparam int idx_w = 8;

  // request queue
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  typedef enum logic {
    op_read,
    op_write
  } mem_op_e;

  // rt sources first, so src value equals rt port number
  typedef enum logic [2:0] {
    src_rt0,
    src_rt1,
    src_rt2,
    src_rt3,
    src_mc
  } mem_src_e;

endpackage
